// ==== rtl/audio_out_top.sv ====
`default_nettype none

module audio_out_top (
    input  wire                     clk245760,
    input  wire                     rst,

    // sample source, four-phase req/ack
    input  wire audio_pkg::sample_t sample_i,
    input  wire                     right_i,
    input  wire                     req_i,
    output wire                     ack_o,

    // serial DAC
    output wire                     dac_bck_o,
    output wire                     dac_lrck_o,
    output wire                     dac_sda_o
);

    sample_if smp_bus ();
    frame_if frm_bus ();

    sample_intake u_intake (
        .clk245760(clk245760),
        .rst(rst),
        .sample_i(sample_i),
        .right_i(right_i),
        .req_i(req_i),
        .ack_o(ack_o),
        .smp(smp_bus.intake)
    );

    frame_assembler u_assembler (
        .clk245760(clk245760),
        .rst(rst),
        .smp(smp_bus.assembler),
        .frm(frm_bus.assembler)
    );

    dac_serializer u_serializer (
        .clk245760(clk245760),
        .rst(rst),
        .frm(frm_bus.serializer),
        .dac_bck_o(dac_bck_o),
        .dac_lrck_o(dac_lrck_o),
        .dac_sda_o(dac_sda_o)
    );

endmodule

`default_nettype wire

// ==== rtl/audio_pkg.sv ====
`default_nettype none

package audio_pkg;

    // one audio sample
    localparam int SAMPLE_WIDTH = 24;
    typedef logic [SAMPLE_WIDTH-1:0] sample_t;

    // serial frame layout
    // each channel slot is the sample MSB first, then zero pad bits
    localparam int SLOT_BITS = 32;
    localparam int BCK_DIV = 4;
    localparam int FRAME_CYCLES = 256;

    // position within the frame period
    typedef logic [7:0] frame_cnt_t;

    // intake queue
    localparam int FIFO_DEPTH = 4;
    typedef logic [1:0] fifo_ptr_t;

endpackage

`default_nettype wire

// ==== rtl/dac_serializer.sv ====
`default_nettype none

module dac_serializer (
    input  wire          clk245760,
    input  wire          rst,
    frame_if.serializer  frm,
    output logic         dac_bck_o,
    output logic         dac_lrck_o,
    output logic         dac_sda_o
);

    audio_pkg::frame_cnt_t cnt;
    // left slot in the upper half, right slot in the lower half
    logic [2*audio_pkg::SLOT_BITS-1:0] shreg;

    logic bit_end;
    logic period_end;
    logic load;

    // last cycle of a serial bit, so the next bit starts on the falling bck
    assign bit_end = (cnt % audio_pkg::BCK_DIV) == audio_pkg::BCK_DIV - 1;
    assign period_end = cnt == audio_pkg::frame_cnt_t'(audio_pkg::FRAME_CYCLES - 1);
    assign load = period_end && frm.req && !frm.ack;

    // bck low for the first half of each bit
    assign dac_bck_o = (cnt % audio_pkg::BCK_DIV) >= audio_pkg::BCK_DIV / 2;
    // lrck low for the left half of the period
    assign dac_lrck_o = cnt >= audio_pkg::FRAME_CYCLES / 2;
    assign dac_sda_o = shreg[2*audio_pkg::SLOT_BITS-1];

    // free running, wraps every frame period
    always_ff @(posedge clk245760) begin
        if (rst) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk245760) begin
        if (rst) begin
            shreg <= '0;
        end else if (period_end) begin
            if (load) begin
                shreg <= {frm.left,
                          {(audio_pkg::SLOT_BITS - audio_pkg::SAMPLE_WIDTH){1'b0}},
                          frm.right_smp,
                          {(audio_pkg::SLOT_BITS - audio_pkg::SAMPLE_WIDTH){1'b0}}};
            end else begin
                // nothing waiting, send a silent period
                shreg <= '0;
            end
        end else if (bit_end) begin
            shreg <= {shreg[2*audio_pkg::SLOT_BITS-2:0], 1'b0};
        end
    end

    // ack rises on load, drops once req is released
    always_ff @(posedge clk245760) begin
        if (rst) begin
            frm.ack <= 1'b0;
        end else if (load) begin
            frm.ack <= 1'b1;
        end else if (!frm.req) begin
            frm.ack <= 1'b0;
        end
    end

    // word clock only toggles at a channel boundary of the counter
    assert property (@(posedge clk245760) disable iff (rst)
        $changed(dac_lrck_o) |->
            ($past(cnt) == audio_pkg::frame_cnt_t'(audio_pkg::FRAME_CYCLES / 2 - 1))
            || ($past(cnt) == audio_pkg::frame_cnt_t'(audio_pkg::FRAME_CYCLES - 1)));

endmodule

`default_nettype wire

// ==== rtl/frame_assembler.sv ====
`default_nettype none

module frame_assembler (
    input wire          clk245760,
    input wire          rst,
    sample_if.assembler smp,
    frame_if.assembler  frm
);

    typedef enum logic [1:0] {
        wait_left,
        wait_right,
        offer
    } state_t;

    state_t state;
    audio_pkg::sample_t pending;
    logic take;

    // no popping while a frame waits or its ack is still high
    assign take = !smp.empty && state != offer && !frm.ack;
    assign smp.pop = take;

    always_ff @(posedge clk245760) begin
        if (rst) begin
            state <= wait_left;
            frm.req <= 1'b0;
        end else begin
            case (state)
                wait_left: begin
                    // an orphan right is just consumed
                    if (take && !smp.right) begin
                        state <= wait_right;
                    end
                end
                wait_right: begin
                    if (take && smp.right) begin
                        frm.req <= 1'b1;
                        state <= offer;
                    end
                end
                offer: begin
                    if (frm.ack) begin
                        frm.req <= 1'b0;
                        state <= wait_left;
                    end
                end
                default: begin
                    state <= wait_left;
                end
            endcase
        end
    end

    // a later left overwrites the pending one
    always_ff @(posedge clk245760) begin
        if (take && !smp.right) begin
            pending <= smp.sample;
        end
        if (take && smp.right && state == wait_right) begin
            frm.left <= pending;
            frm.right_smp <= smp.sample;
        end
    end

    // payload held for the serializer until it acknowledges
    assert property (@(posedge clk245760) disable iff (rst)
        (frm.req && !frm.ack) |=> $stable(frm.left) && $stable(frm.right_smp));

endmodule

`default_nettype wire

// ==== rtl/frame_if.sv ====
`default_nettype none

interface frame_if;

    // four-phase req/ack, payload held from req rise until ack
    logic req;
    logic ack;
    audio_pkg::sample_t left;
    audio_pkg::sample_t right_smp;

    modport assembler (output req, output left, output right_smp, input ack);
    modport serializer (input req, input left, input right_smp, output ack);

endinterface

`default_nettype wire

// ==== rtl/sample_if.sv ====
`default_nettype none

interface sample_if;

    // head of the intake queue, valid while empty is low
    audio_pkg::sample_t sample;
    logic right;
    logic empty;
    // removes the head at the next edge
    logic pop;

    modport intake (output sample, output right, output empty, input pop);
    modport assembler (input sample, input right, input empty, output pop);

endinterface

`default_nettype wire

// ==== rtl/sample_intake.sv ====
`default_nettype none

module sample_intake (
    input  wire                     clk245760,
    input  wire                     rst,
    input  wire audio_pkg::sample_t sample_i,
    input  wire                     right_i,
    input  wire                     req_i,
    output logic                    ack_o,
    sample_if.intake                smp
);

    // queue storage, sample and channel flag side by side
    audio_pkg::sample_t mem_sample [audio_pkg::FIFO_DEPTH];
    logic mem_right [audio_pkg::FIFO_DEPTH];

    audio_pkg::fifo_ptr_t wr_ptr;
    audio_pkg::fifo_ptr_t rd_ptr;
    // one bit wider than the pointers to tell full from empty
    logic [2:0] count;

    logic full;
    logic wr_en;
    logic rd_en;

    assign full = count == 3'(audio_pkg::FIFO_DEPTH);
    assign smp.empty = count == 3'd0;

    // take a new sample only in the idle phase of the handshake
    assign wr_en = req_i && !ack_o && !full;
    assign rd_en = smp.pop && !smp.empty;

    assign smp.sample = mem_sample[rd_ptr];
    assign smp.right = mem_right[rd_ptr];

    // four-phase input handshake
    always_ff @(posedge clk245760) begin
        if (rst) begin
            ack_o <= 1'b0;
        end else if (wr_en) begin
            ack_o <= 1'b1;
        end else if (!req_i) begin
            ack_o <= 1'b0;
        end
    end

    always_ff @(posedge clk245760) begin
        if (wr_en) begin
            mem_sample[wr_ptr] <= sample_i;
            mem_right[wr_ptr] <= right_i;
        end
    end

    // pointers wrap at the queue depth
    always_ff @(posedge clk245760) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ack only answers a request that was already up
    assert property (@(posedge clk245760) disable iff (rst)
        $rose(ack_o) |-> $past(req_i));

    // a sample is never accepted into a full queue
    assert property (@(posedge clk245760) disable iff (rst)
        $rose(ack_o) |-> $past(!full));

endmodule

`default_nettype wire

// ==== sim.f ====
rtl/audio_pkg.sv
rtl/sample_if.sv
rtl/frame_if.sv
rtl/sample_intake.sv
rtl/frame_assembler.sv
rtl/dac_serializer.sv
rtl/audio_out_top.sv
tb/tb_checker.sv
tb/tb_top.sv

// ==== tb/tb_checker.sv ====
`default_nettype none

module tb_checker (
    input  wire                     clk245760,
    input  wire                     rst,
    input  wire audio_pkg::sample_t sample_i,
    input  wire                     right_i,
    input  wire                     req_i,
    input  wire                     ack_i,
    input  wire                     bck_i,
    input  wire                     lrck_i,
    input  wire                     sda_i,
    output int                      errors_o,
    output int                      checks_o,
    output int                      pending_o
);

    // predicted frames with the left sample in the upper half
    logic [2*audio_pkg::SAMPLE_WIDTH-1:0] expect_q [$];
    audio_pkg::sample_t held_left;
    logic have_left;

    logic p_rst;
    logic p_ack;
    logic p_bck;
    logic p_lrck;
    logic [2*audio_pkg::SLOT_BITS-1:0] bits;
    int left_bits;
    int right_bits;
    int since_rise;
    logic seen_rise;

    initial begin
        errors_o = 0;
        checks_o = 0;
        pending_o = 0;
        p_rst = 1'b0;
    end

    task automatic compare(input logic ok, input string msg);
        checks_o++;
        if (!ok) begin
            errors_o++;
            $display("CHECK FAILED at %0t: %s", $time, msg);
        end
    endtask

    task automatic note_problem(input string msg);
        checks_o++;
        errors_o++;
        $display("error at %0t: %s", $time, msg);
    endtask

    // a later left replaces the held one and an orphan right is lost
    task automatic predict_frame(input audio_pkg::sample_t s, input logic is_right);
        if (!is_right) begin
            held_left = s;
            have_left = 1'b1;
        end else if (have_left) begin
            expect_q.push_back({held_left, s});
            have_left = 1'b0;
        end
    endtask

    task automatic close_period();
        logic [2*audio_pkg::SAMPLE_WIDTH-1:0] got;
        logic [2*audio_pkg::SAMPLE_WIDTH-1:0] want;
        got = {bits[63:40], bits[31:8]};
        compare(left_bits == audio_pkg::SLOT_BITS && right_bits == audio_pkg::SLOT_BITS,
            $sformatf("bit count left %0d right %0d, expected 32 each", left_bits, right_bits));
        // all zero is a silent period
        if (bits != '0) begin
            compare(bits[39:32] == 8'h00 && bits[7:0] == 8'h00,
                $sformatf("pad bits not zero in frame %h", bits));
            if (expect_q.size() == 0) begin
                note_problem($sformatf("frame %h came out with no sample pair behind it", got));
            end else begin
                want = expect_q.pop_front();
                compare(got == want, $sformatf("frame got %h expected %h", got, want));
            end
        end
    endtask

    always @(posedge clk245760) begin
        if (rst) begin
            expect_q.delete();
            have_left = 1'b0;
            bits = '0;
            left_bits = 0;
            right_bits = 0;
            since_rise = 0;
            seen_rise = 1'b0;
            p_ack = 1'b0;
            p_bck = 1'b0;
            p_lrck = 1'b0;
        end else begin
            if (p_rst) begin
                compare(!ack_i && !bck_i && !lrck_i && !sda_i,
                    $sformatf("outputs after reset ack %b bck %b lrck %b sda %b",
                        ack_i, bck_i, lrck_i, sda_i));
            end

            // four-phase input handshake
            if (ack_i && !p_ack) begin
                compare(req_i, "ack_o rose while req_i low");
                predict_frame(sample_i, right_i);
            end
            if (!ack_i && p_ack) begin
                compare(!req_i, "ack_o fell while req_i high");
            end

            // data is taken on the rising bit clock
            if (bck_i && !p_bck) begin
                bits = {bits[2*audio_pkg::SLOT_BITS-2:0], sda_i};
                if (lrck_i) begin
                    right_bits++;
                end else begin
                    left_bits++;
                end
            end

            since_rise++;
            if (lrck_i && !p_lrck) begin
                if (seen_rise) begin
                    compare(since_rise == audio_pkg::FRAME_CYCLES,
                        $sformatf("word clock period %0d cycles", since_rise));
                end
                seen_rise = 1'b1;
                since_rise = 0;
            end
            // falling word clock closes a period
            if (!lrck_i && p_lrck) begin
                compare(since_rise == audio_pkg::FRAME_CYCLES / 2,
                    $sformatf("word clock high for %0d cycles", since_rise));
                close_period();
                bits = '0;
                left_bits = 0;
                right_bits = 0;
            end

            p_ack = ack_i;
            p_bck = bck_i;
            p_lrck = lrck_i;
        end
        p_rst = rst;
        pending_o = expect_q.size();
    end

endmodule

`default_nettype wire

// ==== tb/tb_top.sv ====
`default_nettype none

module tb_top;

    typedef struct packed {
        audio_pkg::sample_t sample;
        logic right;
        logic [15:0] gap;
        logic [3:0] test;
    } row_t;

    localparam int ROWS = 36;
    localparam int LIMIT = (ROWS + 8) * 1024;

    logic clk245760;
    logic rst;
    audio_pkg::sample_t sample_i;
    logic right_i;
    logic req_i;
    wire ack_o;
    wire dac_bck_o;
    wire dac_lrck_o;
    wire dac_sda_o;

    int errors;
    int checks;
    int pending;
    int seed = 52653;
    int cycles = 0;
    int errors_before;
    row_t table_rows [ROWS];

    audio_out_top DUT (
        .clk245760(clk245760),
        .rst(rst),
        .sample_i(sample_i),
        .right_i(right_i),
        .req_i(req_i),
        .ack_o(ack_o),
        .dac_bck_o(dac_bck_o),
        .dac_lrck_o(dac_lrck_o),
        .dac_sda_o(dac_sda_o)
    );

    tb_checker chk (
        .clk245760(clk245760),
        .rst(rst),
        .sample_i(sample_i),
        .right_i(right_i),
        .req_i(req_i),
        .ack_i(ack_o),
        .bck_i(dac_bck_o),
        .lrck_i(dac_lrck_o),
        .sda_i(dac_sda_o),
        .errors_o(errors),
        .checks_o(checks),
        .pending_o(pending)
    );

    initial begin
        clk245760 = 1'b0;
        forever #5 clk245760 = ~clk245760;
    end

    always @(posedge clk245760) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic build_table();
        int i;
        // pairs with long gaps
        table_rows[0] = '{24'h7f1234, 1'b0, 16'd300, 4'd2};
        table_rows[1] = '{24'h80abcd, 1'b1, 16'd300, 4'd2};
        table_rows[2] = '{24'h000001, 1'b0, 16'd300, 4'd2};
        table_rows[3] = '{24'hffffff, 1'b1, 16'd300, 4'd2};
        table_rows[4] = '{24'h5a5a5a, 1'b0, 16'd300, 4'd2};
        table_rows[5] = '{24'ha5a5a5, 1'b1, 16'd300, 4'd2};
        // orphan right, then a normal pair
        table_rows[6] = '{24'h123456, 1'b1, 16'd50, 4'd3};
        table_rows[7] = '{24'h234567, 1'b0, 16'd50, 4'd3};
        table_rows[8] = '{24'h345678, 1'b1, 16'd50, 4'd3};
        // second left replaces the first
        table_rows[9] = '{24'h111111, 1'b0, 16'd50, 4'd4};
        table_rows[10] = '{24'h222222, 1'b0, 16'd50, 4'd4};
        table_rows[11] = '{24'h333333, 1'b1, 16'd50, 4'd4};
        // burst with no gaps
        for (i = 0; i < 16; i++) begin
            table_rows[12 + i] = '{24'h100001 + 24'(i * 24'h031415), 1'(i % 2), 16'd0, 4'd5};
        end
        for (i = 0; i < 8; i++) begin
            table_rows[28 + i] = '{24'($random(seed)) | 24'h000001, 1'(i % 2),
                                   16'($unsigned($random(seed)) % 601), 4'd6};
        end
    endtask

    task automatic send_row(input row_t r);
        repeat (r.gap) @(posedge clk245760);
        sample_i <= r.sample;
        right_i <= r.right;
        req_i <= 1'b1;
        @(posedge clk245760);
        while (!ack_o) @(posedge clk245760);
        req_i <= 1'b0;
        @(posedge clk245760);
        while (ack_o) @(posedge clk245760);
    endtask

    // drain predicted frames, then watch a couple of quiet periods
    task automatic finish_test(input int num);
        int new_errors;
        @(negedge clk245760);
        while (pending != 0) @(negedge clk245760);
        repeat (2 * audio_pkg::FRAME_CYCLES) @(negedge clk245760);
        new_errors = errors - errors_before;
        $display("test %0d: %s, %0d errors", num, new_errors == 0 ? "ok" : "bad", new_errors);
        errors_before = errors;
    endtask

    initial begin
        int i;
        rst = 1'b1;
        sample_i = '0;
        right_i = 1'b0;
        req_i = 1'b0;
        errors_before = 0;
        build_table();
        repeat (3) @(posedge clk245760);
        rst <= 1'b0;

        // idle output, word clock and silence only
        repeat (3 * audio_pkg::FRAME_CYCLES) @(posedge clk245760);
        finish_test(1);

        for (i = 0; i < ROWS; i++) begin
            @(posedge clk245760);
            send_row(table_rows[i]);
            if (i == ROWS - 1 || table_rows[i + 1].test != table_rows[i].test) begin
                finish_test(table_rows[i].test);
            end
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
